// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= spmd_host_tb
FILELIST  ?= spmd_host.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -Wno-fatal

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o $(TOP)
	./$(BUILD_DIR)/$(TOP) | tee $(LOG)
	grep -q "\*\*\* TEST PASSED \*\*\*" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== dv/spmd_golden.txt ====
// rows 1-8: image words 0..7; rows 9-14: response address and data
// rows 15-17: expected stat tags, in order of the stat responses
1000a0b1
2000c0d2
3000e0f3
40010104
50023205
60034306
70045407
80056508
00008004 0000a001
00000010 deadbeef
00008004 0000a002
00008000 12345678
00008004 0000a003
00008008 00000001
0000a001
0000a002
0000a003

// ==== dv/spmd_host_tb.sv ====
`default_nettype none

module spmd_host_tb;

  localparam int num_tiles_x_lp  = 2;
  localparam int num_tiles_y_lp  = 2;
  localparam int image_words_lp  = 8;
  localparam int reset_depth_lp  = 3;
  localparam int num_resp_lp     = 6;
  localparam int num_tags_lp     = 3;
  localparam int resp_base_lp    = image_words_lp;
  localparam int tag_base_lp     = resp_base_lp + 2 * num_resp_lp;
  localparam int golden_words_lp = tag_base_lp + num_tags_lp;
  localparam int wait_limit_lp   = 64;

  logic            clk;
  logic            rst_n;
  logic            img_we;
  spmd_pkg::epa_t  img_addr;
  spmd_pkg::data_t img_data;
  logic            tag_done;
  logic            core_reset;
  logic            pkt_v;
  spmd_pkg::cord_t pkt_x;
  spmd_pkg::cord_t pkt_y;
  spmd_pkg::epa_t  pkt_addr;
  spmd_pkg::data_t pkt_data;
  logic            loader_done;
  logic            resp_v;
  spmd_pkg::cord_t resp_x;
  spmd_pkg::cord_t resp_y;
  spmd_pkg::epa_t  resp_addr;
  spmd_pkg::data_t resp_data;
  logic            stat_v;
  spmd_pkg::data_t stat_tag;
  spmd_pkg::data_t stat_cycle;
  logic            finish;

  logic [31:0] golden [golden_words_lp];
  logic [15:0] lfsr_state;
  int          tick;
  int          fall_tick;  // tick at which core reset was seen low
  int          check_errs;
  int          timeout_errs;
  logic        aborted;

  spmd_host_top u_dut (
    .clk_i(clk)
    ,.rst_n_i(rst_n)
    ,.img_we_i(img_we)
    ,.img_addr_i(img_addr)
    ,.img_data_i(img_data)
    ,.tag_done_i(tag_done)
    ,.core_reset_o(core_reset)
    ,.pkt_v_o(pkt_v)
    ,.pkt_x_o(pkt_x)
    ,.pkt_y_o(pkt_y)
    ,.pkt_addr_o(pkt_addr)
    ,.pkt_data_o(pkt_data)
    ,.loader_done_o(loader_done)
    ,.resp_v_i(resp_v)
    ,.resp_x_i(resp_x)
    ,.resp_y_i(resp_y)
    ,.resp_addr_i(resp_addr)
    ,.resp_data_i(resp_data)
    ,.print_stat_v_o(stat_v)
    ,.print_stat_tag_o(stat_tag)
    ,.print_stat_cycle_o(stat_cycle)
    ,.finish_o(finish)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // inputs change and outputs are sampled 2 units after the edge
  task automatic step();
    @(posedge clk);
    #2;
    tick++;
  endtask

  task automatic log_mismatch(input string name, input logic [31:0] exp_v,
                              input logic [31:0] act_v);
    $display("CHECK FAILED %s expected %h actual %h", name, exp_v, act_v);
    check_errs++;
  endtask

  task automatic log_timeout(input string what);
    $display("timeout: %s", what);
    timeout_errs++;
    aborted = 1'b1;
  endtask

  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    lfsr_next = s[0] ? ((s >> 1) ^ 16'hb400) : (s >> 1);
  endfunction

  task automatic take_rand_bits(input int nbits, output int val);
    val = 0;
    for (int i = 0; i < nbits; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      val        = (val << 1) | int'(lfsr_state[0]);
    end
  endtask

  task automatic reset_and_load_image();
    rst_n = 1'b0;
    for (int i = 0; i < 8; i++) begin
      step();
      if (core_reset !== 1'b1) log_mismatch("reset_core_reset", 32'd1, 32'(core_reset));
      if (pkt_v !== 1'b0) log_mismatch("reset_pkt_v", 32'd0, 32'(pkt_v));
      if (loader_done !== 1'b0) log_mismatch("reset_loader_done", 32'd0, 32'(loader_done));
      if (stat_v !== 1'b0) log_mismatch("reset_stat_v", 32'd0, 32'(stat_v));
      if (finish !== 1'b0) log_mismatch("reset_finish", 32'd0, 32'(finish));
    end
    rst_n = 1'b1;
    for (int w = 0; w < image_words_lp; w++) begin
      img_we   = 1'b1;
      img_addr = spmd_pkg::epa_t'(w);
      img_data = golden[w];
      step();
    end
    img_we = 1'b0;
  endtask

  task automatic release_core_reset();
    int n;
    n        = 0;
    tag_done = 1'b1;
    step();  // edge that samples tag done
    while (core_reset && n < wait_limit_lp) begin
      step();
      n++;
    end
    if (core_reset) begin
      log_timeout("core reset was never released");
    end else begin
      if (n != reset_depth_lp) log_mismatch("reset_depth", 32'(reset_depth_lp), 32'(n));
      fall_tick = tick;
    end
  endtask

  task automatic collect_packets();
    int waited;
    int seen;
    logic [31:0] exp_addr;
    logic [31:0] exp_data;
    waited = 0;
    seen   = 0;
    while (!pkt_v && waited < wait_limit_lp) begin
      step();
      waited++;
    end
    if (!pkt_v) begin
      log_timeout("no packet left the loader");
    end else begin
      if (tick - fall_tick != 2) log_mismatch("first_pkt_delay", 32'd2, 32'(tick - fall_tick));
      for (int ty = 0; ty < num_tiles_y_lp; ty++) begin
        for (int tx = 0; tx < num_tiles_x_lp; tx++) begin
          for (int w = 0; w <= image_words_lp; w++) begin
            if (w == image_words_lp) begin  // unfreeze packet
              exp_addr = 32'(spmd_pkg::freeze_addr_c);
              exp_data = 32'd0;
            end else begin
              exp_addr = 32'(w);
              exp_data = golden[w];
            end
            if (pkt_v) seen++;
            if (pkt_v !== 1'b1) log_mismatch("pkt_v", 32'd1, 32'(pkt_v));
            if (pkt_x !== 7'(tx)) log_mismatch("pkt_x", 32'(tx), 32'(pkt_x));
            if (pkt_y !== 7'(ty)) log_mismatch("pkt_y", 32'(ty), 32'(pkt_y));
            if (32'(pkt_addr) !== exp_addr) log_mismatch("pkt_addr", exp_addr, 32'(pkt_addr));
            if (pkt_data !== exp_data) log_mismatch("pkt_data", exp_data, pkt_data);
            if (loader_done !== 1'b0) log_mismatch("early_done", 32'd0, 32'(loader_done));
            step();
          end
        end
      end
      if (seen != num_tiles_x_lp * num_tiles_y_lp * (image_words_lp + 1)) begin
        log_mismatch("pkt_count", 32'(num_tiles_x_lp * num_tiles_y_lp * (image_words_lp + 1)),
                     32'(seen));
      end
      if (pkt_v !== 1'b0) log_mismatch("pkt_v_after_last", 32'd0, 32'(pkt_v));
      if (loader_done !== 1'b1) log_mismatch("loader_done", 32'd1, 32'(loader_done));
    end
  endtask

  task automatic run_responses();
    int gap;
    int k;
    int pulses;
    logic [31:0] exp_cycle;
    logic is_stat;
    logic finish_seen;
    k           = 0;
    pulses      = 0;
    finish_seen = 1'b0;
    for (int i = 0; i < num_resp_lp; i++) begin
      take_rand_bits(2, gap);
      for (int j = 0; j < gap; j++) begin
        step();
        if (stat_v !== 1'b0) log_mismatch("idle_stat_v", 32'd0, 32'(stat_v));
        if (finish !== finish_seen) log_mismatch("idle_finish", 32'(finish_seen), 32'(finish));
      end
      resp_v    = 1'b1;
      resp_x    = 7'(i % num_tiles_x_lp);
      resp_y    = 7'(i / num_tiles_x_lp);
      resp_addr = spmd_pkg::epa_t'(golden[resp_base_lp + 2 * i]);
      resp_data = golden[resp_base_lp + 2 * i + 1];
      is_stat   = (resp_addr == spmd_pkg::stat_addr_c);
      exp_cycle = 32'(tick - fall_tick);  // counter value in this cycle
      if (resp_addr == spmd_pkg::finish_addr_c) finish_seen = 1'b1;
      step();
      resp_v = 1'b0;
      if (stat_v === 1'b1) pulses++;
      if (is_stat) begin
        if (stat_v !== 1'b1) log_mismatch("stat_v", 32'd1, 32'(stat_v));
        if (stat_tag !== golden[tag_base_lp + k]) begin
          log_mismatch("stat_tag", golden[tag_base_lp + k], stat_tag);
        end
        if (stat_cycle !== exp_cycle) log_mismatch("stat_cycle", exp_cycle, stat_cycle);
        k++;
      end else begin
        if (stat_v !== 1'b0) log_mismatch("ignored_resp", 32'd0, 32'(stat_v));
      end
      if (finish !== finish_seen) log_mismatch("finish", 32'(finish_seen), 32'(finish));
    end
    if (pulses != num_tags_lp) log_mismatch("stat_count", 32'(num_tags_lp), 32'(pulses));
    for (int j = 0; j < 4; j++) begin
      step();
      if (finish !== 1'b1) log_mismatch("finish_sticky", 32'd1, 32'(finish));
      if (stat_v !== 1'b0) log_mismatch("late_stat_v", 32'd0, 32'(stat_v));
    end
  endtask

  initial begin
    rst_n        = 1'b0;
    img_we       = 1'b0;
    img_addr     = '0;
    img_data     = '0;
    tag_done     = 1'b0;
    resp_v       = 1'b0;
    resp_x       = '0;
    resp_y       = '0;
    resp_addr    = '0;
    resp_data    = '0;
    lfsr_state   = 16'd10;
    tick         = 0;
    fall_tick    = 0;
    check_errs   = 0;
    timeout_errs = 0;
    aborted      = 1'b0;
    $readmemh("dv/spmd_golden.txt", golden);

    reset_and_load_image();
    release_core_reset();
    if (!aborted) collect_packets();
    if (!aborted) run_responses();

    $display("errors: %0d check, %0d timeout", check_errs, timeout_errs);
    if (check_errs == 0 && timeout_errs == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== hdl/spmd_cycle_counter.sv ====
`default_nettype none

module spmd_cycle_counter (
  input  logic            clk_i
  ,input  logic            rst_n_i
  ,input  logic            core_reset_i
  ,output spmd_pkg::data_t count_o
);

  // zero in the first cycle out of core reset
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      count_o <= '0;
    end else if (core_reset_i) begin
      count_o <= '0;
    end else begin
      count_o <= count_o + 1'b1;
    end
  end

endmodule

`default_nettype wire

// ==== hdl/spmd_host_top.sv ====
`default_nettype none

module spmd_host_top #(
  parameter int num_tiles_x_p = 2
  ,parameter int num_tiles_y_p = 2
  ,parameter int image_words_p = 8
  ,parameter int reset_depth_p = 3
) (
  input  logic            clk_i
  ,input  logic            rst_n_i

  ,input  logic            img_we_i
  ,input  spmd_pkg::epa_t  img_addr_i
  ,input  spmd_pkg::data_t img_data_i

  ,input  logic            tag_done_i
  ,output logic            core_reset_o

  ,output logic            pkt_v_o
  ,output spmd_pkg::cord_t pkt_x_o
  ,output spmd_pkg::cord_t pkt_y_o
  ,output spmd_pkg::epa_t  pkt_addr_o
  ,output spmd_pkg::data_t pkt_data_o
  ,output logic            loader_done_o

  ,input  logic            resp_v_i
  ,input  spmd_pkg::cord_t resp_x_i  // source tile, not decoded
  ,input  spmd_pkg::cord_t resp_y_i
  ,input  spmd_pkg::epa_t  resp_addr_i
  ,input  spmd_pkg::data_t resp_data_i

  ,output logic            print_stat_v_o
  ,output spmd_pkg::data_t print_stat_tag_o
  ,output spmd_pkg::data_t print_stat_cycle_o
  ,output logic            finish_o
);

  spmd_pkg::data_t cycle_cnt;

  spmd_load_if ld (.clk_i(clk_i));

  spmd_loader_fsm #(
    .num_tiles_x_p(num_tiles_x_p)
    ,.num_tiles_y_p(num_tiles_y_p)
    ,.image_words_p(image_words_p)
    ,.reset_depth_p(reset_depth_p)
  ) u_loader (
    .clk_i(clk_i)
    ,.rst_n_i(rst_n_i)
    ,.tag_done_i(tag_done_i)
    ,.core_reset_o(core_reset_o)
    ,.loader_done_o(loader_done_o)
    ,.ld(ld.loader)
  );

  // host writes land only while the tiles sit in reset
  spmd_image_mem #(
    .image_words_p(image_words_p)
  ) u_image_mem (
    .clk_i(clk_i)
    ,.img_we_i(img_we_i & core_reset_o)
    ,.img_addr_i(img_addr_i)
    ,.img_data_i(img_data_i)
    ,.ld(ld.mem)
  );

  spmd_pkt_encoder #(
    .num_tiles_x_p(num_tiles_x_p)
  ) u_encoder (
    .clk_i(clk_i)
    ,.rst_n_i(rst_n_i)
    ,.ld(ld.encoder)
    ,.pkt_v_o(pkt_v_o)
    ,.pkt_x_o(pkt_x_o)
    ,.pkt_y_o(pkt_y_o)
    ,.pkt_addr_o(pkt_addr_o)
    ,.pkt_data_o(pkt_data_o)
  );

  spmd_cycle_counter u_cycle_ctr (
    .clk_i(clk_i)
    ,.rst_n_i(rst_n_i)
    ,.core_reset_i(core_reset_o)
    ,.count_o(cycle_cnt)
  );

  spmd_resp_decoder u_resp_dec (
    .clk_i(clk_i)
    ,.rst_n_i(rst_n_i)
    ,.resp_v_i(resp_v_i)
    ,.resp_addr_i(resp_addr_i)
    ,.resp_data_i(resp_data_i)
    ,.cycle_i(cycle_cnt)
    ,.print_stat_v_o(print_stat_v_o)
    ,.print_stat_tag_o(print_stat_tag_o)
    ,.print_stat_cycle_o(print_stat_cycle_o)
    ,.finish_o(finish_o)
  );

endmodule

`default_nettype wire

// ==== hdl/spmd_image_mem.sv ====
`default_nettype none

module spmd_image_mem #(
  parameter int image_words_p = 8
) (
  input  logic            clk_i
  ,input  logic            img_we_i
  ,input  spmd_pkg::epa_t  img_addr_i
  ,input  spmd_pkg::data_t img_data_i
  ,spmd_load_if.mem        ld
);

  localparam int idx_w_lp = (image_words_p > 1) ? $clog2(image_words_p) : 1;

  spmd_pkg::data_t mem_r [image_words_p];

  // one image shared by all tiles
  always_ff @(posedge clk_i) begin
    if (img_we_i && (img_addr_i < spmd_pkg::epa_t'(image_words_p))) begin
      mem_r[img_addr_i[idx_w_lp-1:0]] <= img_data_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (ld.rd_en) begin
      ld.rd_data <= mem_r[ld.rd_addr[idx_w_lp-1:0]];
    end
  end

endmodule

`default_nettype wire

// ==== hdl/spmd_load_if.sv ====
`default_nettype none

interface spmd_load_if (
  input logic clk_i
);

  logic            rd_en;     // image word step
  spmd_pkg::epa_t  rd_addr;   // word index
  spmd_pkg::epa_t  tile_idx;  // row-major tile number
  logic            unfreeze;  // freeze register step
  logic            last;
  spmd_pkg::data_t rd_data;   // one cycle after rd_en

  modport loader (input clk_i, output rd_en, rd_addr, tile_idx, unfreeze, last);

  modport mem (input clk_i, input rd_en, rd_addr, output rd_data);

  modport encoder (input clk_i, input rd_en, rd_addr, tile_idx, unfreeze, rd_data);

endinterface

`default_nettype wire

// ==== hdl/spmd_loader_fsm.sv ====
`default_nettype none

module spmd_loader_fsm #(
  parameter int num_tiles_x_p = 2
  ,parameter int num_tiles_y_p = 2
  ,parameter int image_words_p = 8
  ,parameter int reset_depth_p = 3
) (
  input  logic        clk_i
  ,input  logic        rst_n_i
  ,input  logic        tag_done_i
  ,output logic        core_reset_o
  ,output logic        loader_done_o
  ,spmd_load_if.loader ld
);

  localparam int num_tiles_lp = num_tiles_x_p * num_tiles_y_p;
  localparam int hold_w_lp    = $clog2(reset_depth_p + 1);

  spmd_pkg::loader_state_e state_r;
  spmd_pkg::epa_t          word_r;
  spmd_pkg::epa_t          tile_r;
  logic [hold_w_lp-1:0]    hold_cnt_r;
  logic                    done_d_r;  // matches the memory stage

  assign ld.rd_en    = (state_r == spmd_pkg::LOAD);
  assign ld.rd_addr  = word_r;
  assign ld.tile_idx = tile_r;
  assign ld.unfreeze = (state_r == spmd_pkg::UNFREEZE);
  assign ld.last     = ld.unfreeze && (tile_r == spmd_pkg::epa_t'(num_tiles_lp - 1));

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_r      <= spmd_pkg::IDLE;
      core_reset_o <= 1'b1;
      word_r       <= '0;
      tile_r       <= '0;
      hold_cnt_r   <= '0;
    end else begin
      unique case (state_r)
        spmd_pkg::IDLE, spmd_pkg::WAIT_TAG: begin
          hold_cnt_r <= '0;
          if (tag_done_i) begin
            state_r <= spmd_pkg::RESET_HOLD;
          end else begin
            state_r <= spmd_pkg::WAIT_TAG;
          end
        end
        spmd_pkg::RESET_HOLD: begin
          if (hold_cnt_r == hold_w_lp'(reset_depth_p - 1)) begin
            core_reset_o <= 1'b0;  // tiles out of reset, still frozen
            state_r      <= spmd_pkg::LOAD;
          end else begin
            hold_cnt_r <= hold_cnt_r + 1'b1;
          end
        end
        spmd_pkg::LOAD: begin
          if (word_r == spmd_pkg::epa_t'(image_words_p - 1)) begin
            state_r <= spmd_pkg::UNFREEZE;
          end else begin
            word_r <= word_r + 1'b1;
          end
        end
        spmd_pkg::UNFREEZE: begin
          word_r <= '0;
          if (ld.last) begin
            state_r <= spmd_pkg::DONE;
          end else begin
            tile_r  <= tile_r + 1'b1;  // next tile, row-major
            state_r <= spmd_pkg::LOAD;
          end
        end
        spmd_pkg::DONE: state_r <= spmd_pkg::DONE;
        default: state_r <= spmd_pkg::IDLE;
      endcase
    end
  end

  // done trails the packet pipeline by two stages
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      done_d_r      <= 1'b0;
      loader_done_o <= 1'b0;
    end else begin
      done_d_r      <= (state_r == spmd_pkg::DONE);
      loader_done_o <= done_d_r;
    end
  end

endmodule

`default_nettype wire

// ==== hdl/spmd_pkg.sv ====
`default_nettype none

package spmd_pkg;

  typedef logic [31:0] data_t;  // network data word
  typedef logic [15:0] epa_t;   // word address inside a tile
  typedef logic [6:0]  cord_t;  // tile coordinate, x or y

  // special tile addresses, kept above any image word index
  localparam epa_t freeze_addr_c = 16'h8000;
  localparam epa_t stat_addr_c   = 16'h8004;
  localparam epa_t finish_addr_c = 16'h8008;

  typedef enum logic [2:0] {
    IDLE,
    WAIT_TAG,
    RESET_HOLD,
    LOAD,
    UNFREEZE,
    DONE
  } loader_state_e;

endpackage

`default_nettype wire

// ==== hdl/spmd_pkt_encoder.sv ====
`default_nettype none

module spmd_pkt_encoder #(
  parameter int num_tiles_x_p = 2
) (
  input  logic             clk_i
  ,input  logic             rst_n_i
  ,spmd_load_if.encoder     ld
  ,output logic             pkt_v_o
  ,output spmd_pkg::cord_t  pkt_x_o
  ,output spmd_pkg::cord_t  pkt_y_o
  ,output spmd_pkg::epa_t   pkt_addr_o
  ,output spmd_pkg::data_t  pkt_data_o
);

  // step fields delayed to line up with the memory word
  logic           s1_v_r;
  logic           s1_unfreeze_r;
  spmd_pkg::epa_t s1_tile_r;
  spmd_pkg::epa_t s1_word_r;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      s1_v_r  <= 1'b0;
      pkt_v_o <= 1'b0;
    end else begin
      s1_v_r  <= ld.rd_en | ld.unfreeze;
      pkt_v_o <= s1_v_r;
    end
  end

  always_ff @(posedge clk_i) begin
    s1_unfreeze_r <= ld.unfreeze;
    s1_tile_r     <= ld.tile_idx;
    s1_word_r     <= ld.rd_addr;
  end

  always_ff @(posedge clk_i) begin
    if (s1_v_r) begin
      pkt_x_o <= spmd_pkg::cord_t'(s1_tile_r % spmd_pkg::epa_t'(num_tiles_x_p));
      pkt_y_o <= spmd_pkg::cord_t'(s1_tile_r / spmd_pkg::epa_t'(num_tiles_x_p));
      if (s1_unfreeze_r) begin
        pkt_addr_o <= spmd_pkg::freeze_addr_c;
        pkt_data_o <= '0;  // 0 releases the tile
      end else begin
        pkt_addr_o <= s1_word_r;
        pkt_data_o <= ld.rd_data;
      end
    end
  end

endmodule

`default_nettype wire

// ==== hdl/spmd_resp_decoder.sv ====
`default_nettype none

module spmd_resp_decoder (
  input  logic            clk_i
  ,input  logic            rst_n_i
  ,input  logic            resp_v_i
  ,input  spmd_pkg::epa_t  resp_addr_i
  ,input  spmd_pkg::data_t resp_data_i
  ,input  spmd_pkg::data_t cycle_i
  ,output logic            print_stat_v_o
  ,output spmd_pkg::data_t print_stat_tag_o
  ,output spmd_pkg::data_t print_stat_cycle_o
  ,output logic            finish_o
);

  logic stat_hit;
  logic finish_hit;

  assign stat_hit   = resp_v_i && (resp_addr_i == spmd_pkg::stat_addr_c);
  assign finish_hit = resp_v_i && (resp_addr_i == spmd_pkg::finish_addr_c);

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      print_stat_v_o <= 1'b0;
      finish_o       <= 1'b0;
    end else begin
      print_stat_v_o <= stat_hit;  // single cycle pulse
      finish_o       <= finish_o | finish_hit;  // sticky
    end
  end

  // cycle stamp taken in the request cycle
  always_ff @(posedge clk_i) begin
    if (stat_hit) begin
      print_stat_tag_o   <= resp_data_i;
      print_stat_cycle_o <= cycle_i;
    end
  end

endmodule

`default_nettype wire

// ==== spmd_host.f ====
hdl/spmd_pkg.sv
hdl/spmd_load_if.sv
hdl/spmd_image_mem.sv
hdl/spmd_pkt_encoder.sv
hdl/spmd_loader_fsm.sv
hdl/spmd_cycle_counter.sv
hdl/spmd_resp_decoder.sv
hdl/spmd_host_top.sv
dv/spmd_host_tb.sv
